// File: rtl/avr_decode_settings.svh
`ifndef AVR_DECODE_SETTINGS_SVH
`define AVR_DECODE_SETTINGS_SVH

// Instruction word as fetched from program memory
`define INSTR_WIDTH 16

// Register file has 32 entries
`define REG_ADDR_WIDTH 5

// Immediate field, wide enough for the rcall and rjmp offsets
`define IMD_WIDTH 12

// Bit index for sbi, cbi and the branch flag select
`define BIT_WIDTH 3

// I/O address of SREG
`define SREG_ADDR 63

// Global interrupt enable position in SREG
`define FLAG_I 7

`endif

// File: rtl/avr_decode_pkg.sv
package avr_decode_pkg;

    // Decoded instruction types
    // Nop sits at zero so the reset value of the output register is a nop
    typedef enum logic [5:0] {
        TYPE_NOP,
        TYPE_ADD,
        TYPE_ADC,
        TYPE_AND,
        TYPE_BRBC,
        TYPE_BRBS,
        TYPE_CBI,
        TYPE_CLI,
        TYPE_CP,
        TYPE_DEC,
        TYPE_EOR,
        TYPE_IN,
        TYPE_INC,
        TYPE_LD_Y,
        TYPE_LDI,
        TYPE_LDS,
        TYPE_MOV,
        TYPE_NEG,
        TYPE_OR,
        TYPE_OUT,
        TYPE_POP,
        TYPE_PUSH,
        TYPE_RCALL,
        TYPE_RET,
        TYPE_RETI,
        TYPE_RJMP,
        TYPE_SBI,
        TYPE_SEI,
        TYPE_SUB,
        TYPE_SUBI,
        TYPE_STS,
        TYPE_UNKNOWN,
        // Virtual instruction inserted on an interrupt request
        TYPE_CALL_ISR
    } opcode_t;

    // Bit positions inside the group vector
    typedef enum logic [4:0] {
        GROUP_ALU_AUX,
        GROUP_ALU_IMD,
        GROUP_ALU_ONE_OP,
        GROUP_ALU_TWO_OP,
        GROUP_ALU,
        GROUP_LOAD_DIRECT,
        GROUP_LOAD_INDIRECT,
        GROUP_LOAD,
        GROUP_STORE_DIRECT,
        GROUP_STORE_INDIRECT,
        GROUP_STORE,
        GROUP_STACK,
        GROUP_MEMORY,
        GROUP_REGISTER,
        GROUP_CONTROL_FLOW,
        GROUP_IO_READ,
        GROUP_IO_WRITE,
        GROUP_TWO_CYCLE_MEM,
        GROUP_TWO_CYCLE_WB,
        GROUP_TWO_CYCLE_ID
    } group_idx_t;

    // Width of the group vector, follows the last group index
    localparam int GROUP_COUNT = int'(GROUP_TWO_CYCLE_ID) + 1;

endpackage

// File: rtl/opcode_matcher.sv
`timescale 1ns/1ps
`include "avr_decode_settings.svh"

module opcode_matcher (
    input  logic [`INSTR_WIDTH-1:0] instruction,
    input  logic                    irq,
    output avr_decode_pkg::opcode_t match_opcode
);

    import avr_decode_pkg::*;

    always_comb begin
        if (irq) begin
            // Pending interrupt replaces whatever word was fetched
            match_opcode = TYPE_CALL_ISR;
        end else begin
            // First matching pattern wins
            casez (instruction)
                // Two register arithmetic and logic
                16'b0000_11??_????_????: match_opcode = TYPE_ADD;
                16'b0001_11??_????_????: match_opcode = TYPE_ADC;
                16'b0010_00??_????_????: match_opcode = TYPE_AND;
                16'b0001_01??_????_????: match_opcode = TYPE_CP;
                16'b0010_01??_????_????: match_opcode = TYPE_EOR;
                16'b0010_10??_????_????: match_opcode = TYPE_OR;
                16'b0001_10??_????_????: match_opcode = TYPE_SUB;
                16'b0010_11??_????_????: match_opcode = TYPE_MOV;

                // Conditional branches on an SREG bit
                16'b1111_01??_????_????: match_opcode = TYPE_BRBC;
                16'b1111_00??_????_????: match_opcode = TYPE_BRBS;

                // Bit operations in the low I/O space
                16'b1001_1000_????_????: match_opcode = TYPE_CBI;
                16'b1001_1010_????_????: match_opcode = TYPE_SBI;

                // Interrupt enable control, fixed encodings
                16'b1001_0100_1111_1000: match_opcode = TYPE_CLI;
                16'b1001_0100_0111_1000: match_opcode = TYPE_SEI;

                // Single register operations
                16'b1001_010?_????_1010: match_opcode = TYPE_DEC;
                16'b1001_010?_????_0011: match_opcode = TYPE_INC;
                16'b1001_010?_????_0001: match_opcode = TYPE_NEG;

                // I/O port transfers
                16'b1011_0???_????_????: match_opcode = TYPE_IN;
                16'b1011_1???_????_????: match_opcode = TYPE_OUT;

                // Loads
                16'b1000_000?_????_1000: match_opcode = TYPE_LD_Y;
                16'b1110_????_????_????: match_opcode = TYPE_LDI;
                16'b1010_0???_????_????: match_opcode = TYPE_LDS;

                // Store direct
                16'b1010_1???_????_????: match_opcode = TYPE_STS;

                // Immediate subtract on the upper registers
                16'b0101_????_????_????: match_opcode = TYPE_SUBI;

                // Stack
                16'b1001_000?_????_1111: match_opcode = TYPE_POP;
                16'b1001_001?_????_1111: match_opcode = TYPE_PUSH;

                // Calls, returns and jumps
                16'b1101_????_????_????: match_opcode = TYPE_RCALL;
                16'b1001_0101_0000_1000: match_opcode = TYPE_RET;
                16'b1001_0101_0001_1000: match_opcode = TYPE_RETI;
                16'b1100_????_????_????: match_opcode = TYPE_RJMP;

                16'b0000_0000_0000_0000: match_opcode = TYPE_NOP;

                default: match_opcode = TYPE_UNKNOWN;
            endcase
        end
    end

endmodule

// File: rtl/operand_extractor.sv
`timescale 1ns/1ps
`include "avr_decode_settings.svh"

module operand_extractor (
    input  logic [`INSTR_WIDTH-1:0]    instruction,
    input  avr_decode_pkg::opcode_t    match_opcode,
    output logic [`REG_ADDR_WIDTH-1:0] rd_next,
    output logic [`REG_ADDR_WIDTH-1:0] rr_next,
    output logic [`IMD_WIDTH-1:0]      imd_next,
    output logic [`BIT_WIDTH-1:0]      bit_next
);

    import avr_decode_pkg::*;

    // Register fields shared by most encodings
    logic [`REG_ADDR_WIDTH-1:0] reg_d;
    logic [`REG_ADDR_WIDTH-1:0] reg_r;
    logic [`REG_ADDR_WIDTH-1:0] reg_upper;

    // 7-bit data address of lds and sts, with the complemented top bit in front
    logic [7:0] data_addr;

    assign reg_d     = instruction[8:4];
    assign reg_r     = {instruction[9], instruction[3:0]};
    // Only r16..r31 are reachable from the immediate forms
    assign reg_upper = {1'b1, instruction[7:4]};
    assign data_addr = {~instruction[8], instruction[8], instruction[10:9], instruction[3:0]};

    always_comb begin
        rd_next  = '0;
        rr_next  = '0;
        imd_next = '0;
        bit_next = '0;

        case (match_opcode)
            TYPE_ADD, TYPE_ADC, TYPE_AND, TYPE_CP,
            TYPE_EOR, TYPE_OR, TYPE_SUB, TYPE_MOV: begin
                rd_next = reg_d;
                rr_next = reg_r;
            end

            TYPE_DEC, TYPE_INC, TYPE_NEG, TYPE_LD_Y, TYPE_POP: begin
                rd_next = reg_d;
            end

            TYPE_PUSH: begin
                rr_next = reg_d;
            end

            // Flag select in the low bits, signed word offset above it
            TYPE_BRBC, TYPE_BRBS: begin
                bit_next = instruction[2:0];
                imd_next = {{5{instruction[9]}}, instruction[9:3]};
            end

            TYPE_CBI, TYPE_SBI: begin
                bit_next = instruction[2:0];
                imd_next = {7'b0, instruction[7:3]};
            end

            // Same datapath as sbi and cbi, aimed at the I bit of SREG
            TYPE_CLI, TYPE_SEI: begin
                bit_next = `BIT_WIDTH'(`FLAG_I);
                imd_next = `IMD_WIDTH'(`SREG_ADDR);
            end

            TYPE_IN: begin
                rd_next  = reg_d;
                imd_next = {6'b0, instruction[10:9], instruction[3:0]};
            end

            TYPE_OUT: begin
                rr_next  = reg_d;
                imd_next = {6'b0, instruction[10:9], instruction[3:0]};
            end

            TYPE_LDI, TYPE_SUBI: begin
                rd_next  = reg_upper;
                imd_next = {4'b0, instruction[11:8], instruction[3:0]};
            end

            TYPE_LDS: begin
                rd_next  = reg_upper;
                imd_next = {4'b0, data_addr};
            end

            TYPE_STS: begin
                rr_next  = reg_upper;
                imd_next = {4'b0, data_addr};
            end

            // Relative word offset, sign handled by the PC adder
            TYPE_RCALL, TYPE_RJMP: begin
                imd_next = instruction[11:0];
            end

            // nop, ret, reti, call_isr and unknown carry no operands
            default: begin
                rd_next = '0;
            end
        endcase
    end

endmodule

// File: rtl/group_classifier.sv
`timescale 1ns/1ps

module group_classifier (
    input  avr_decode_pkg::opcode_t                   match_opcode,
    output logic [avr_decode_pkg::GROUP_COUNT-1:0]    groups_next
);

    import avr_decode_pkg::*;

    // Read-modify-write on a single I/O bit
    // reti and call_isr also touch the I flag
    assign groups_next[GROUP_ALU_AUX] = match_opcode inside {
        TYPE_SBI, TYPE_CBI, TYPE_SEI, TYPE_CLI, TYPE_RETI, TYPE_CALL_ISR
    };

    assign groups_next[GROUP_ALU_IMD] = match_opcode inside {TYPE_INC, TYPE_DEC};

    assign groups_next[GROUP_ALU_ONE_OP] = (match_opcode == TYPE_NEG);

    assign groups_next[GROUP_ALU_TWO_OP] = match_opcode inside {
        TYPE_ADD, TYPE_ADC, TYPE_SUB, TYPE_AND, TYPE_EOR, TYPE_OR, TYPE_CP
    };

    assign groups_next[GROUP_ALU] = groups_next[GROUP_ALU_ONE_OP] |
                                    groups_next[GROUP_ALU_TWO_OP];

    assign groups_next[GROUP_LOAD_DIRECT] = (match_opcode == TYPE_LDS);

    // Returns pop the PC off the stack
    assign groups_next[GROUP_LOAD_INDIRECT] = match_opcode inside {
        TYPE_LD_Y, TYPE_POP, TYPE_RET, TYPE_RETI
    };

    assign groups_next[GROUP_LOAD] = groups_next[GROUP_LOAD_DIRECT] |
                                     groups_next[GROUP_LOAD_INDIRECT];

    assign groups_next[GROUP_STORE_DIRECT] = (match_opcode == TYPE_STS);

    assign groups_next[GROUP_STORE_INDIRECT] = match_opcode inside {TYPE_PUSH, TYPE_RCALL};

    assign groups_next[GROUP_STORE] = groups_next[GROUP_STORE_DIRECT] |
                                      groups_next[GROUP_STORE_INDIRECT];

    assign groups_next[GROUP_STACK] = match_opcode inside {
        TYPE_PUSH, TYPE_POP, TYPE_RCALL, TYPE_RET, TYPE_RETI, TYPE_CALL_ISR
    };

    assign groups_next[GROUP_MEMORY] = groups_next[GROUP_LOAD] | groups_next[GROUP_STORE];

    assign groups_next[GROUP_REGISTER] = match_opcode inside {TYPE_LDI, TYPE_MOV};

    assign groups_next[GROUP_CONTROL_FLOW] = match_opcode inside {
        TYPE_BRBS, TYPE_BRBC, TYPE_RJMP, TYPE_RCALL, TYPE_RET, TYPE_RETI, TYPE_CALL_ISR
    };

    // adc reads the carry from SREG, stack ops read SP
    assign groups_next[GROUP_IO_READ] = (match_opcode == TYPE_IN)  |
                                        (match_opcode == TYPE_ADC) |
                                        groups_next[GROUP_STACK]   |
                                        groups_next[GROUP_ALU_AUX];

    // ALU ops update SREG, stack ops update SP
    assign groups_next[GROUP_IO_WRITE] = (match_opcode == TYPE_OUT) |
                                         groups_next[GROUP_ALU]     |
                                         groups_next[GROUP_STACK]   |
                                         groups_next[GROUP_ALU_AUX];

    // PC is wider than a data byte, so it moves in two memory cycles
    assign groups_next[GROUP_TWO_CYCLE_MEM] = match_opcode inside {
        TYPE_RCALL, TYPE_RET, TYPE_RETI, TYPE_CALL_ISR
    };

    // SP and SREG both written back
    assign groups_next[GROUP_TWO_CYCLE_WB] = match_opcode inside {TYPE_CALL_ISR, TYPE_RETI};

    // SP and SREG both read in decode
    assign groups_next[GROUP_TWO_CYCLE_ID] = match_opcode inside {TYPE_CALL_ISR, TYPE_RETI};

    // The memory stage drives one transfer direction per instruction
    load_store_excl: assert final (!(groups_next[GROUP_LOAD] && groups_next[GROUP_STORE]))
        else $error("opcode %s is both a load and a store", match_opcode.name());

endmodule

// File: rtl/decode_unit.sv
`timescale 1ns/1ps
`include "avr_decode_settings.svh"

module decode_unit (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  instr_valid,
    input  logic [`INSTR_WIDTH-1:0]               instruction,
    input  logic                                  irq,
    output logic                                  decoded_valid,
    output avr_decode_pkg::opcode_t               opcode,
    output logic [`REG_ADDR_WIDTH-1:0]            rd,
    output logic [`REG_ADDR_WIDTH-1:0]            rr,
    output logic [`IMD_WIDTH-1:0]                 imd,
    output logic [`BIT_WIDTH-1:0]                 bit_idx,
    output logic [avr_decode_pkg::GROUP_COUNT-1:0] groups
);

    import avr_decode_pkg::*;

    opcode_t                    match_opcode;
    logic [`REG_ADDR_WIDTH-1:0] rd_next;
    logic [`REG_ADDR_WIDTH-1:0] rr_next;
    logic [`IMD_WIDTH-1:0]      imd_next;
    logic [`BIT_WIDTH-1:0]      bit_next;
    logic [GROUP_COUNT-1:0]     groups_next;

    opcode_matcher u_matcher (
        .instruction  (instruction),
        .irq          (irq),
        .match_opcode (match_opcode)
    );

    operand_extractor u_extractor (
        .instruction  (instruction),
        .match_opcode (match_opcode),
        .rd_next      (rd_next),
        .rr_next      (rr_next),
        .imd_next     (imd_next),
        .bit_next     (bit_next)
    );

    group_classifier u_classifier (
        .match_opcode (match_opcode),
        .groups_next  (groups_next)
    );

    // Single output stage, updated only on a valid word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decoded_valid <= 1'b0;
            opcode        <= TYPE_NOP;
            rd            <= '0;
            rr            <= '0;
            imd           <= '0;
            bit_idx       <= '0;
            groups        <= '0;
        end else begin
            decoded_valid <= instr_valid;
            if (instr_valid) begin
                opcode  <= match_opcode;
                rd      <= rd_next;
                rr      <= rr_next;
                imd     <= imd_next;
                bit_idx <= bit_next;
                groups  <= groups_next;
            end
        end
    end

    valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> (decoded_valid == $past(instr_valid)));

    // Interrupt entry has to save both SP and SREG
    call_isr_wb: assert property (@(posedge clk) disable iff (!rst_n)
        (opcode == TYPE_CALL_ISR) |-> groups[GROUP_TWO_CYCLE_WB]);

    unknown_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (opcode == TYPE_UNKNOWN) |-> (rd == '0 && rr == '0 && imd == '0 && bit_idx == '0));

endmodule

// File: test/decode_checker.sv
`timescale 1ns/1ps
`include "avr_decode_settings.svh"

module decode_checker (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   instr_valid,
    input  avr_decode_pkg::opcode_t                exp_opcode,
    input  logic [`REG_ADDR_WIDTH-1:0]             exp_rd,
    input  logic [`REG_ADDR_WIDTH-1:0]             exp_rr,
    input  logic [`IMD_WIDTH-1:0]                  exp_imd,
    input  logic [`BIT_WIDTH-1:0]                  exp_bit,
    input  logic [avr_decode_pkg::GROUP_COUNT-1:0] exp_groups,
    input  logic                                   decoded_valid,
    input  avr_decode_pkg::opcode_t                opcode,
    input  logic [`REG_ADDR_WIDTH-1:0]             rd,
    input  logic [`REG_ADDR_WIDTH-1:0]             rr,
    input  logic [`IMD_WIDTH-1:0]                  imd,
    input  logic [`BIT_WIDTH-1:0]                  bit_idx,
    input  logic [avr_decode_pkg::GROUP_COUNT-1:0] groups
);

    import avr_decode_pkg::*;

    // Expected register contents, nop and zero out of reset
    logic                       pending;
    opcode_t                    hold_opcode;
    logic [`REG_ADDR_WIDTH-1:0] hold_rd;
    logic [`REG_ADDR_WIDTH-1:0] hold_rr;
    logic [`IMD_WIDTH-1:0]      hold_imd;
    logic [`BIT_WIDTH-1:0]      hold_bit;
    logic [GROUP_COUNT-1:0]     hold_groups;

    int test_checks;
    int test_errors;
    int total_checks;
    int total_errors;
    int tests_run;
    int tests_failed;

    initial begin
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
    end

    // Capture what the DUT samples on the same edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending     <= 1'b0;
            hold_opcode <= TYPE_NOP;
            hold_rd     <= '0;
            hold_rr     <= '0;
            hold_imd    <= '0;
            hold_bit    <= '0;
            hold_groups <= '0;
        end else begin
            pending <= instr_valid;
            if (instr_valid) begin
                hold_opcode <= exp_opcode;
                hold_rd     <= exp_rd;
                hold_rr     <= exp_rr;
                hold_imd    <= exp_imd;
                hold_bit    <= exp_bit;
                hold_groups <= exp_groups;
            end
        end
    end

    task automatic fail(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        test_errors++;
        total_errors++;
    endtask

    // Outputs settle after the rising edge, compare them mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            test_checks++;
            total_checks++;
            if (decoded_valid !== pending)
                fail($sformatf("decoded_valid %b, expected %b", decoded_valid, pending));
            if (opcode !== hold_opcode)
                fail($sformatf("opcode %s, expected %s", opcode.name(), hold_opcode.name()));
            if (rd !== hold_rd)
                fail($sformatf("%s rd %0d, expected %0d", hold_opcode.name(), rd, hold_rd));
            if (rr !== hold_rr)
                fail($sformatf("%s rr %0d, expected %0d", hold_opcode.name(), rr, hold_rr));
            if (imd !== hold_imd)
                fail($sformatf("%s imd %h, expected %h", hold_opcode.name(), imd, hold_imd));
            if (bit_idx !== hold_bit)
                fail($sformatf("%s bit_idx %0d, expected %0d",
                               hold_opcode.name(), bit_idx, hold_bit));
            if (groups !== hold_groups)
                fail($sformatf("%s groups %b, expected %b",
                               hold_opcode.name(), groups, hold_groups));
        end
    end

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("Test %s: failed, %0d errors in %0d checks", name, test_errors, test_checks);
        end else begin
            $display("Test %s: passed, %0d checks", name, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

endmodule

// File: test/tb_decode_unit.sv
`timescale 1ns/1ps
`include "avr_decode_settings.svh"

module tb_decode_unit;

    import avr_decode_pkg::*;

    localparam int RESET_CYCLES  = 10;
    localparam int SEED          = 10198;
    localparam int PATTERN_REPS  = 8;
    localparam int PATTERN_COUNT = 31;
    localparam int RANDOM_WORDS  = 200;
    localparam int IRQ_WORDS     = 64;
    localparam int MIXED_WORDS   = 150;
    localparam int DRAIN_CYCLES  = 4;
    localparam int IDLE_CYCLES   = 16;

    // Worst case cycles per test, mixed words may each be followed by one gap
    localparam int TEST_CYCLES = IDLE_CYCLES + PATTERN_COUNT * PATTERN_REPS + RANDOM_WORDS
                                 + IRQ_WORDS + 2 * MIXED_WORDS + 5 * DRAIN_CYCLES;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + RESET_CYCLES;

    logic                        clk;
    logic                        rst_n;
    logic                        instr_valid;
    logic [`INSTR_WIDTH-1:0]     instruction;
    logic                        irq;
    logic                        decoded_valid;
    opcode_t                     opcode;
    logic [`REG_ADDR_WIDTH-1:0]  rd;
    logic [`REG_ADDR_WIDTH-1:0]  rr;
    logic [`IMD_WIDTH-1:0]       imd;
    logic [`BIT_WIDTH-1:0]       bit_idx;
    logic [GROUP_COUNT-1:0]      groups;

    opcode_t                     exp_opcode;
    logic [`REG_ADDR_WIDTH-1:0]  exp_rd;
    logic [`REG_ADDR_WIDTH-1:0]  exp_rr;
    logic [`IMD_WIDTH-1:0]       exp_imd;
    logic [`BIT_WIDTH-1:0]       exp_bit;
    logic [GROUP_COUNT-1:0]      exp_groups;

    logic [15:0] lfsr_state;
    int          cycle_count;

    // Fixed bits of each supported encoding in priority order
    // The rest of a stimulus word is filled from the LFSR
    logic [15:0] pat_mask   [PATTERN_COUNT];
    logic [15:0] pat_value  [PATTERN_COUNT];
    opcode_t     pat_opcode [PATTERN_COUNT];

    decode_unit UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instruction   (instruction),
        .irq           (irq),
        .decoded_valid (decoded_valid),
        .opcode        (opcode),
        .rd            (rd),
        .rr            (rr),
        .imd           (imd),
        .bit_idx       (bit_idx),
        .groups        (groups)
    );

    decode_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .exp_opcode    (exp_opcode),
        .exp_rd        (exp_rd),
        .exp_rr        (exp_rr),
        .exp_imd       (exp_imd),
        .exp_bit       (exp_bit),
        .exp_groups    (exp_groups),
        .decoded_valid (decoded_valid),
        .opcode        (opcode),
        .rd            (rd),
        .rr            (rr),
        .imd           (imd),
        .bit_idx       (bit_idx),
        .groups        (groups)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Reference opcode match, the first entry of the encoding table wins
    function automatic opcode_t ref_opcode(input logic [15:0] w, input logic i);
        if (i) begin
            return TYPE_CALL_ISR;
        end
        for (int p = 0; p < PATTERN_COUNT; p++) begin
            if ((w & pat_mask[p]) == pat_value[p]) begin
                return pat_opcode[p];
            end
        end
        return TYPE_UNKNOWN;
    endfunction

    // Operand fields packed as {rd, rr, imd, bit}
    function automatic logic [24:0] ref_fields(input logic [15:0] w, input opcode_t op);
        logic [4:0]  f_rd;
        logic [4:0]  f_rr;
        logic [11:0] f_imd;
        logic [2:0]  f_bit;
        logic [7:0]  addr;
        f_rd  = '0;
        f_rr  = '0;
        f_imd = '0;
        f_bit = '0;
        addr  = {~w[8], w[8], w[10:9], w[3:0]};
        case (op)
            TYPE_ADD, TYPE_ADC, TYPE_AND, TYPE_CP, TYPE_EOR, TYPE_OR, TYPE_SUB, TYPE_MOV: begin
                f_rd = w[8:4];
                f_rr = {w[9], w[3:0]};
            end
            TYPE_DEC, TYPE_INC, TYPE_NEG, TYPE_LD_Y, TYPE_POP: f_rd = w[8:4];
            TYPE_PUSH: f_rr = w[8:4];
            TYPE_BRBC, TYPE_BRBS: begin
                f_bit = w[2:0];
                f_imd = {{5{w[9]}}, w[9:3]};
            end
            TYPE_CBI, TYPE_SBI: begin
                f_bit = w[2:0];
                f_imd = 12'(w[7:3]);
            end
            TYPE_CLI, TYPE_SEI: begin
                f_bit = 3'd7;
                f_imd = 12'd63;
            end
            TYPE_IN: begin
                f_rd  = w[8:4];
                f_imd = 12'({w[10:9], w[3:0]});
            end
            TYPE_OUT: begin
                f_rr  = w[8:4];
                f_imd = 12'({w[10:9], w[3:0]});
            end
            TYPE_LDI, TYPE_SUBI: begin
                f_rd  = {1'b1, w[7:4]};
                f_imd = 12'({w[11:8], w[3:0]});
            end
            TYPE_LDS: begin
                f_rd  = {1'b1, w[7:4]};
                f_imd = 12'(addr);
            end
            TYPE_STS: begin
                f_rr  = {1'b1, w[7:4]};
                f_imd = 12'(addr);
            end
            TYPE_RCALL, TYPE_RJMP: f_imd = w[11:0];
            default: f_rd = '0;
        endcase
        return {f_rd, f_rr, f_imd, f_bit};
    endfunction

    // Group membership lists, composites filled in afterwards
    function automatic logic [GROUP_COUNT-1:0] ref_groups(input opcode_t op);
        logic [GROUP_COUNT-1:0] g;
        g = '0;
        g[GROUP_ALU_AUX] = op inside {TYPE_SBI, TYPE_CBI, TYPE_SEI, TYPE_CLI,
                                      TYPE_RETI, TYPE_CALL_ISR};
        g[GROUP_ALU_IMD] = op inside {TYPE_INC, TYPE_DEC};
        g[GROUP_ALU_ONE_OP] = (op == TYPE_NEG);
        g[GROUP_ALU_TWO_OP] = op inside {TYPE_ADD, TYPE_ADC, TYPE_SUB, TYPE_AND,
                                         TYPE_EOR, TYPE_OR, TYPE_CP};
        g[GROUP_LOAD_DIRECT] = (op == TYPE_LDS);
        g[GROUP_LOAD_INDIRECT] = op inside {TYPE_LD_Y, TYPE_POP, TYPE_RET, TYPE_RETI};
        g[GROUP_STORE_DIRECT] = (op == TYPE_STS);
        g[GROUP_STORE_INDIRECT] = op inside {TYPE_PUSH, TYPE_RCALL};
        g[GROUP_STACK] = op inside {TYPE_PUSH, TYPE_POP, TYPE_RCALL, TYPE_RET,
                                    TYPE_RETI, TYPE_CALL_ISR};
        g[GROUP_REGISTER] = op inside {TYPE_LDI, TYPE_MOV};
        g[GROUP_CONTROL_FLOW] = op inside {TYPE_BRBS, TYPE_BRBC, TYPE_RJMP, TYPE_RCALL,
                                           TYPE_RET, TYPE_RETI, TYPE_CALL_ISR};
        g[GROUP_TWO_CYCLE_MEM] = op inside {TYPE_RCALL, TYPE_RET, TYPE_RETI, TYPE_CALL_ISR};
        g[GROUP_TWO_CYCLE_WB] = op inside {TYPE_CALL_ISR, TYPE_RETI};
        g[GROUP_TWO_CYCLE_ID] = op inside {TYPE_CALL_ISR, TYPE_RETI};
        g[GROUP_ALU] = g[GROUP_ALU_ONE_OP] | g[GROUP_ALU_TWO_OP];
        g[GROUP_LOAD] = g[GROUP_LOAD_DIRECT] | g[GROUP_LOAD_INDIRECT];
        g[GROUP_STORE] = g[GROUP_STORE_DIRECT] | g[GROUP_STORE_INDIRECT];
        g[GROUP_MEMORY] = g[GROUP_LOAD] | g[GROUP_STORE];
        g[GROUP_IO_READ] = (op == TYPE_IN) | (op == TYPE_ADC) | g[GROUP_STACK]
                           | g[GROUP_ALU_AUX];
        g[GROUP_IO_WRITE] = (op == TYPE_OUT) | g[GROUP_ALU] | g[GROUP_STACK]
                            | g[GROUP_ALU_AUX];
        return g;
    endfunction

    // Expectation for the word currently on the inputs
    always_comb begin
        exp_opcode = ref_opcode(instruction, irq);
        {exp_rd, exp_rr, exp_imd, exp_bit} = ref_fields(instruction, exp_opcode);
        exp_groups = ref_groups(exp_opcode);
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    task automatic send_word(input logic [15:0] w, input logic i);
        @(posedge clk);
        instr_valid <= 1'b1;
        instruction <= w;
        irq         <= i;
    endtask

    // Idle cycles keep the bus busy with noise that must not be decoded
    task automatic idle(input int n);
        logic [15:0] noise;
        for (int k = 0; k < n; k++) begin
            rand_bits(16, noise);
            @(posedge clk);
            instr_valid <= 1'b0;
            instruction <= noise;
            irq         <= noise[0];
        end
    endtask

    task automatic init_patterns();
        logic [15:0] full;
        logic [15:0] two_reg;
        logic [15:0] one_reg;
        full    = 16'hFFFF;
        two_reg = 16'hFC00;
        one_reg = 16'hFE0F;
        pat_value  = '{16'h0C00, 16'h1C00, 16'h2000, 16'h1400, 16'h2400, 16'h2800, 16'h1800,
                       16'h2C00, 16'hF400, 16'hF000, 16'h9800, 16'h9A00, 16'h94F8, 16'h9478,
                       16'h940A, 16'h9403, 16'h9401, 16'hB000, 16'hB800, 16'h8008, 16'hE000,
                       16'hA000, 16'hA800, 16'h5000, 16'h900F, 16'h920F, 16'hD000, 16'h9508,
                       16'h9518, 16'hC000, 16'h0000};
        pat_mask   = '{two_reg, two_reg, two_reg, two_reg, two_reg, two_reg, two_reg,
                       two_reg, two_reg, two_reg, 16'hFF00, 16'hFF00, full, full,
                       one_reg, one_reg, one_reg, 16'hF800, 16'hF800, one_reg, 16'hF000,
                       16'hF800, 16'hF800, 16'hF000, one_reg, one_reg, 16'hF000, full,
                       full, 16'hF000, full};
        pat_opcode = '{TYPE_ADD, TYPE_ADC, TYPE_AND, TYPE_CP, TYPE_EOR, TYPE_OR, TYPE_SUB,
                       TYPE_MOV, TYPE_BRBC, TYPE_BRBS, TYPE_CBI, TYPE_SBI, TYPE_CLI, TYPE_SEI,
                       TYPE_DEC, TYPE_INC, TYPE_NEG, TYPE_IN, TYPE_OUT, TYPE_LD_Y, TYPE_LDI,
                       TYPE_LDS, TYPE_STS, TYPE_SUBI, TYPE_POP, TYPE_PUSH, TYPE_RCALL,
                       TYPE_RET, TYPE_RETI, TYPE_RJMP, TYPE_NOP};
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [15:0] w;
        logic [15:0] gap;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instruction = '0;
        irq         = 1'b0;
        cycle_count = 0;
        lfsr_state  = 16'(SEED);
        init_patterns();

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Outputs must stay at nop and zero while nothing is sent
        idle(IDLE_CYCLES);
        u_checker.report_test("reset_state");

        for (int p = 0; p < PATTERN_COUNT; p++) begin
            for (int r = 0; r < PATTERN_REPS; r++) begin
                rand_bits(16, w);
                send_word((w & ~pat_mask[p]) | pat_value[p], 1'b0);
            end
        end
        idle(DRAIN_CYCLES);
        u_checker.report_test("opcode_patterns");

        for (int k = 0; k < RANDOM_WORDS; k++) begin
            rand_bits(16, w);
            send_word(w, 1'b0);
        end
        idle(DRAIN_CYCLES);
        u_checker.report_test("random_words");

        for (int k = 0; k < IRQ_WORDS; k++) begin
            rand_bits(16, w);
            send_word(w, 1'b1);
        end
        idle(DRAIN_CYCLES);
        u_checker.report_test("interrupt");

        // Back-to-back words mixed with single idle gaps
        for (int k = 0; k < MIXED_WORDS; k++) begin
            rand_bits(16, w);
            rand_bits(3, gap);
            send_word(w, gap[2:0] == 3'b111);
            rand_bits(1, gap);
            if (gap[0]) begin
                idle(1);
            end
        end
        idle(DRAIN_CYCLES);
        u_checker.report_test("valid_timing");

        $display("Tests: %0d run, %0d failed, %0d checks, %0d errors",
                 u_checker.tests_run, u_checker.tests_failed,
                 u_checker.total_checks, u_checker.total_errors);
        if (u_checker.total_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+rtl
rtl/avr_decode_pkg.sv
rtl/opcode_matcher.sv
rtl/operand_extractor.sv
rtl/group_classifier.sv
rtl/decode_unit.sv
test/decode_checker.sv
test/tb_decode_unit.sv

// File: Bender.yml
package:
  name: avr_decode

export_include_dirs:
  - rtl

sources:
  - rtl/avr_decode_pkg.sv
  - rtl/opcode_matcher.sv
  - rtl/operand_extractor.sv
  - rtl/group_classifier.sv
  - rtl/decode_unit.sv
  - target: test
    files:
      - test/decode_checker.sv
      - test/tb_decode_unit.sv
